// ==== stream_core.f ====
verilog/stream_core_pkg.sv
verilog/sdp_bram.sv
verilog/launch_delay.sv
verilog/inst_mem.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/stream_core.sv
testbench/result_checker.sv
testbench/stream_core_sva.sv
testbench/tb_stream_core.sv

// ==== Makefile ====
# Verilator flow for the stream_core testbench

VERILATOR ?= verilator
TOP       ?= tb_stream_core
FILELIST  ?= stream_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_stream_core.sv ====
module tb_stream_core
  import stream_core_pkg::*;
();

  localparam int DELAY          = 16;
  localparam int ADDR_WIDTH     = 8;
  localparam int RAND_COUNT     = 300;       // Past 256 so both counters wrap
  localparam int RAND_MIN_BURST = DELAY / 2;
  localparam int RAND_BURSTS    = (RAND_COUNT + RAND_MIN_BURST - 1) / RAND_MIN_BURST;
  localparam int TOTAL_INSTR    = 27 + RAND_COUNT + 3; // Table, random, reset test
  localparam int TOTAL_BURSTS   = 4 + RAND_BURSTS + 2;
  localparam int TIMEOUT        = TOTAL_INSTR + TOTAL_BURSTS * (2 * DELAY + 8) + 200;

  typedef struct packed {
    logic [INST_WIDTH-1:0]     inst;
    logic                      last;    // Idle after this beat
    logic                      has_res; // Result pulse expected
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     data;
  } stim_t;

  logic                      clk;
  logic                      rst;
  logic                      inst_in_v;
  logic [INST_WIDTH-1:0]     inst_in;
  logic                      res_v;
  logic [REG_ADDR_WIDTH-1:0] res_rd;
  logic [DATA_WIDTH-1:0]     res_data;
  logic                      exp_v;     // Expected result strobe to the checker
  logic [REG_ADDR_WIDTH-1:0] exp_rd;
  logic [DATA_WIDTH-1:0]     exp_data;
  logic                      chk_done;
  int                        err_count;
  int                        chk_count;
  int                        cycle_cnt;
  int                        seed = 32'h3200_9817;
  stim_t                     stim_tbl [$];
  logic [DATA_WIDTH-1:0]     model_regs [8]; // Expected register contents

  stream_core #(.DELAY(DELAY), .ADDR_WIDTH(ADDR_WIDTH)) dut (
    .clk (clk), .rst (rst), .inst_in_v (inst_in_v), .inst_in (inst_in),
    .res_v (res_v), .res_rd (res_rd), .res_data (res_data)
  );

  result_checker u_check (
    .clk (clk), .rst (rst), .res_v (res_v), .res_rd (res_rd), .res_data (res_data),
    .exp_v (exp_v), .exp_rd (exp_rd), .exp_data (exp_data), .done (chk_done),
    .err_count (err_count), .chk_count (chk_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Encoding and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [INST_WIDTH-1:0] enc_imm(input logic [3:0] op,
      input logic [2:0] rd, input logic [IMM_WIDTH-1:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [INST_WIDTH-1:0] enc_reg(input logic [3:0] op,
      input logic [2:0] rd, input logic [2:0] rs1, input logic [2:0] rs2);
    return {op, rd, rs1, rs2, 23'd0};
  endfunction

  function automatic logic [DATA_WIDTH-1:0] model_alu(input logic [3:0] op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
      input logic [IMM_WIDTH-1:0] imm);
    case (op)
      4'd1:    return {3'b000, imm}; // Zero-extended load
      4'd2:    return a + b;
      4'd3:    return a - b;
      4'd4:    return a & b;
      4'd5:    return a | b;
      4'd6:    return a ^ b;
      default: return 32'd0;
    endcase
  endfunction

  task automatic add_res(input logic [INST_WIDTH-1:0] inst, input logic [2:0] rd,
      input logic [DATA_WIDTH-1:0] data, input logic last);
    stim_tbl.push_back({inst, last, 1'b1, rd, data});
  endtask

  task automatic add_none(input logic [INST_WIDTH-1:0] inst, input logic last);
    stim_tbl.push_back({inst, last, 1'b0, 3'd0, 32'd0});
  endtask

  task automatic build_table;
    // Loads into every register
    add_res(enc_imm(op_ldi, 3'd0, 29'h0000_0005), 3'd0, 32'h0000_0005, 1'b0);
    add_res(enc_imm(op_ldi, 3'd1, 29'h0000_0003), 3'd1, 32'h0000_0003, 1'b0);
    add_res(enc_imm(op_ldi, 3'd2, 29'h1FFF_FFFF), 3'd2, 32'h1FFF_FFFF, 1'b0);
    add_res(enc_imm(op_ldi, 3'd3, 29'h1234_5678), 3'd3, 32'h1234_5678, 1'b0);
    add_res(enc_imm(op_ldi, 3'd4, 29'h0F0F_0F0F), 3'd4, 32'h0F0F_0F0F, 1'b0);
    add_res(enc_imm(op_ldi, 3'd5, 29'h00FF_00FF), 3'd5, 32'h00FF_00FF, 1'b0);
    add_res(enc_imm(op_ldi, 3'd6, 29'h0000_0000), 3'd6, 32'h0000_0000, 1'b0);
    add_res(enc_imm(op_ldi, 3'd7, 29'h1ABC_DEF0), 3'd7, 32'h1ABC_DEF0, 1'b1);
    // ALU ops with r6 as scratch
    add_res(enc_reg(op_add, 3'd6, 3'd2, 3'd3), 3'd6, 32'h3234_5677, 1'b0);
    add_res(enc_reg(op_sub, 3'd6, 3'd1, 3'd0), 3'd6, 32'hFFFF_FFFE, 1'b0); // 3 - 5
    add_res(enc_reg(op_and, 3'd6, 3'd4, 3'd5), 3'd6, 32'h000F_000F, 1'b0);
    add_res(enc_reg(op_or,  3'd6, 3'd4, 3'd5), 3'd6, 32'h0FFF_0FFF, 1'b0);
    add_res(enc_reg(op_xor, 3'd6, 3'd3, 3'd7), 3'd6, 32'h0888_8888, 1'b0);
    add_res(enc_reg(op_sub, 3'd6, 3'd0, 3'd1), 3'd6, 32'h0000_0002, 1'b1);
    // Each op reads the write just before it
    add_res(enc_reg(op_add, 3'd7, 3'd0, 3'd1), 3'd7, 32'h0000_0008, 1'b0);
    add_res(enc_reg(op_add, 3'd7, 3'd7, 3'd7), 3'd7, 32'h0000_0010, 1'b0);
    add_res(enc_reg(op_sub, 3'd7, 3'd7, 3'd0), 3'd7, 32'h0000_000B, 1'b0);
    add_res(enc_reg(op_xor, 3'd0, 3'd7, 3'd1), 3'd0, 32'h0000_0008, 1'b0);
    add_res(enc_reg(op_and, 3'd1, 3'd0, 3'd7), 3'd1, 32'h0000_0008, 1'b0);
    add_res(enc_reg(op_or,  3'd2, 3'd1, 3'd7), 3'd2, 32'h0000_000B, 1'b1);
    // Nop and undefined codes mixed in
    add_res(enc_imm(op_ldi, 3'd5, 29'h0000_0100), 3'd5, 32'h0000_0100, 1'b0);
    add_none(enc_imm(op_nop, 3'd3, 29'h0000_1555), 1'b0);
    add_res(enc_reg(op_add, 3'd3, 3'd5, 3'd0), 3'd3, 32'h0000_0108, 1'b0);
    add_none(enc_reg(4'd7, 3'd1, 3'd2, 3'd3), 1'b0);
    add_none(enc_imm(4'd15, 3'd2, 29'h1FFF_FFFF), 1'b0);
    add_res(enc_reg(op_sub, 3'd4, 3'd3, 3'd5), 3'd4, 32'h0000_0008, 1'b0);
    add_none(enc_reg(4'd12, 3'd0, 3'd0, 3'd0), 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driving
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_beat(input logic [INST_WIDTH-1:0] inst, input logic has_res,
      input logic [2:0] rd, input logic [DATA_WIDTH-1:0] data);
    @(posedge clk);
    #1;
    inst_in_v = 1'b1;
    inst_in   = inst;
    exp_v     = has_res; // Checker queues it at the next edge
    exp_rd    = rd;
    exp_data  = data;
    if (has_res) begin
      model_regs[rd] = data;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      inst_in_v = 1'b0;
      exp_v     = 1'b0;
    end
  endtask

  task automatic run_table;
    foreach (stim_tbl[i]) begin
      drive_beat(stim_tbl[i].inst, stim_tbl[i].has_res, stim_tbl[i].rd,
                 stim_tbl[i].data);
      if (stim_tbl[i].last) begin
        idle_cycles(DELAY + 4); // Let the whole burst replay
      end
    end
  endtask

  task automatic run_random(input int count);
    int                    left;
    int                    len;
    logic [31:0]           rnd;
    logic [31:0]           rnd2;
    logic [3:0]            op;
    logic [2:0]            rd;
    logic [2:0]            rs1;
    logic [2:0]            rs2;
    logic [INST_WIDTH-1:0] inst;
    logic [DATA_WIDTH-1:0] val;
    logic                  wr;
    left = count;
    while (left > 0) begin
      rnd = $random(seed);
      len = RAND_MIN_BURST + (int'(rnd[7:0]) % (DELAY - RAND_MIN_BURST + 1));
      if (len > left) begin
        len = left;
      end
      for (int k = 0; k < len; k++) begin
        rnd  = $random(seed);
        rnd2 = $random(seed);
        // Mostly defined ops with a quarter raw codes including nop
        op   = (rnd[31:30] == 2'b00) ? rnd[3:0] : 4'(1 + int'(rnd[7:4]) % 6);
        rd   = rnd[10:8];
        rs1  = rnd[13:11];
        rs2  = rnd[16:14];
        inst = (op == 4'd1) ? enc_imm(op, rd, rnd2[28:0]) : {op, rd, rs1, rs2, rnd2[22:0]};
        wr   = (op >= 4'd1) && (op <= 4'd6);
        val  = model_alu(op, model_regs[rs1], model_regs[rs2], rnd2[28:0]);
        drive_beat(inst, wr, rd, val);
      end
      idle_cycles(DELAY + 4);
      left = left - len;
    end
  endtask

  task automatic reset_then_add;
    drive_beat(enc_imm(op_ldi, 3'd2, 29'h0000_0ABC), 1'b1, 3'd2, 32'h0000_0ABC);
    drive_beat(enc_imm(op_ldi, 3'd7, 29'h0000_0055), 1'b1, 3'd7, 32'h0000_0055);
    idle_cycles(DELAY + 4);
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    model_regs = '{default: 32'd0}; // Register file cleared
    drive_beat(enc_reg(op_add, 3'd4, 3'd2, 3'd7), 1'b1, 3'd4, 32'd0);
    idle_cycles(DELAY + 4);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main flow and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    inst_in_v  = 1'b0;
    inst_in    = '0;
    exp_v      = 1'b0;
    exp_rd     = '0;
    exp_data   = '0;
    chk_done   = 1'b0;
    model_regs = '{default: 32'd0};
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    run_table();
    run_random(RAND_COUNT);
    reset_then_add();
    @(posedge clk);
    #1;
    chk_done = 1'b1; // Flush check for missing results
    @(posedge clk);
    #1;
    chk_done = 1'b0;
    @(posedge clk);
    #1;
    $display("results checked %0d, errors %0d, assertion failures %0d", chk_count,
             err_count, dut.u_sva.fail_count);
    if (err_count == 0 && dut.u_sva.fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the test did not finish within %0d cycles", TIMEOUT);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== testbench/stream_core_sva.sv ====
module stream_core_sva #(
  parameter int DELAY = 16
) (
  input logic clk,
  input logic rst,
  input logic inst_in_v,
  input logic run_en,
  input logic inst_out_v,
  input logic ram_we,
  input logic res_v
);

  int fail_count = 0; // Failed assertion count

  // Nop beats give no pulse and only the forward direction holds
  a_res_latency: assert property (@(posedge clk) disable iff (rst)
    res_v |-> $past(inst_in_v, DELAY + 2))
    else begin
      fail_count++;
      $error("result pulse with no input beat %0d cycles earlier", DELAY + 2);
    end

  // Reset and one cycle after it
  a_out_v_reset: assert property (@(posedge clk)
    ($past(rst) || $past(rst, 2)) |-> !inst_out_v)
    else begin
      fail_count++;
      $error("instruction valid high during or right after reset");
    end

  // Loads are gated off during replay
  a_no_write_in_run: assert property (@(posedge clk)
    !(ram_we && run_en))
    else begin
      fail_count++;
      $error("RAM written while replay is running");
    end

endmodule

bind stream_core stream_core_sva #(.DELAY(DELAY)) u_sva (
  .clk (clk), .rst (rst), .inst_in_v (inst_in_v), .run_en (run_en),
  .inst_out_v (inst_out_v), .ram_we (u_mem.wr_en), .res_v (res_v)
);

// ==== testbench/result_checker.sv ====
module result_checker
  import stream_core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  // DUT result side
  input  logic                      res_v,
  input  logic [REG_ADDR_WIDTH-1:0] res_rd,
  input  logic [DATA_WIDTH-1:0]     res_data,
  // Expected values from the stimulus
  input  logic                      exp_v,
  input  logic [REG_ADDR_WIDTH-1:0] exp_rd,
  input  logic [DATA_WIDTH-1:0]     exp_data,
  input  logic                      done,      // End of stimulus
  output int                        err_count,
  output int                        chk_count
);

  logic [REG_ADDR_WIDTH+DATA_WIDTH-1:0] exp_q [$]; // Oldest expected first
  int                                   errs   = 0;
  int                                   checks = 0;

  always @(posedge clk) begin : compare
    logic [REG_ADDR_WIDTH-1:0] want_rd;
    logic [DATA_WIDTH-1:0]     want_data;
    // Results come back in issue order
    if (!rst && res_v) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result at %0t: r%0d = %08h arrived with nothing expected",
                 $time, res_rd, res_data);
        errs++;
      end else begin
        {want_rd, want_data} = exp_q.pop_front();
        checks++;
        if (res_rd !== want_rd || res_data !== want_data) begin
          $display("error at %0t: expected r%0d = %08h, got r%0d = %08h",
                   $time, want_rd, want_data, res_rd, res_data);
          errs++;
        end
      end
    end
    if (exp_v) begin
      exp_q.push_back({exp_rd, exp_data});
    end
    // Anything left over never came out
    if (done && exp_q.size() != 0) begin
      $display("missing results: %0d expected results never appeared", exp_q.size());
      errs = errs + exp_q.size();
      exp_q.delete();
    end
  end

  assign err_count = errs;
  assign chk_count = checks;

endmodule

// ==== verilog/stream_core.sv ====
module stream_core
  import stream_core_pkg::*;
#(
  parameter int DELAY      = 16, // Load to replay distance
  parameter int ADDR_WIDTH = 8   // Instruction memory depth is 2**ADDR_WIDTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_in_v,
  input  logic [INST_WIDTH-1:0]     inst_in,
  output logic                      res_v,
  output logic [REG_ADDR_WIDTH-1:0] res_rd,
  output logic [DATA_WIDTH-1:0]     res_data
);

  logic                      run_en;     // Replay strobe from the timer
  logic                      inst_out_v;
  logic [INST_WIDTH-1:0]     inst_out;
  logic [REG_ADDR_WIDTH-1:0] rs1;
  logic [REG_ADDR_WIDTH-1:0] rs2;
  logic [DATA_WIDTH-1:0]     rdata1;
  logic [DATA_WIDTH-1:0]     rdata2;
  logic                      rf_we;
  logic [REG_ADDR_WIDTH-1:0] rf_wa;
  logic [DATA_WIDTH-1:0]     rf_wd;

  launch_delay #(.DELAY(DELAY)) u_delay (
    .clk (clk), .rst (rst), .v_in (inst_in_v), .v_out (run_en)
  );

  // Load at t, read at t+DELAY, instruction valid at t+DELAY+1
  inst_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
    .clk (clk), .rst (rst), .inst_in_v (inst_in_v), .inst_in (inst_in),
    .run_en (run_en), .inst_out_v (inst_out_v), .inst_out (inst_out)
  );

  reg_file u_rf (
    .clk (clk), .rst (rst), .rs1 (rs1), .rs2 (rs2), .rdata1 (rdata1),
    .rdata2 (rdata2), .we (rf_we), .wa (rf_wa), .wd (rf_wd)
  );

  // Result at t+DELAY+2
  exec_unit u_exec (
    .clk (clk), .rst (rst), .inst_v (inst_out_v), .inst (inst_out),
    .rs1 (rs1), .rs2 (rs2), .rdata1 (rdata1), .rdata2 (rdata2),
    .we (rf_we), .wa (rf_wa), .wd (rf_wd),
    .res_v (res_v), .res_rd (res_rd), .res_data (res_data)
  );

endmodule

// ==== verilog/exec_unit.sv ====
module exec_unit
  import stream_core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      inst_v,
  input  inst_word_u                inst,
  // Register file read side
  output logic [REG_ADDR_WIDTH-1:0] rs1,
  output logic [REG_ADDR_WIDTH-1:0] rs2,
  input  logic [DATA_WIDTH-1:0]     rdata1,
  input  logic [DATA_WIDTH-1:0]     rdata2,
  // Register file write side
  output logic                      we,
  output logic [REG_ADDR_WIDTH-1:0] wa,
  output logic [DATA_WIDTH-1:0]     wd,
  // Result pulse
  output logic                      res_v,
  output logic [REG_ADDR_WIDTH-1:0] res_rd,
  output logic [DATA_WIDTH-1:0]     res_data
);

  logic                  op_ok;  // Opcode writes a register
  logic [DATA_WIDTH-1:0] result;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and ALU
  ////////////////////////////////////////////////////////////////////////////

  // Sources only mean something in the reg view
  assign rs1 = inst.r.rs1;
  assign rs2 = inst.r.rs2;

  always_comb begin
    op_ok  = 1'b1;
    result = '0;
    case (inst.r.op)
      op_ldi:  result = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, inst.i.imm};
      op_add:  result = rdata1 + rdata2;
      op_sub:  result = rdata1 - rdata2; // Wraps mod 2^32
      op_and:  result = rdata1 & rdata2;
      op_or:   result = rdata1 | rdata2;
      op_xor:  result = rdata1 ^ rdata2;
      default: op_ok  = 1'b0;            // nop and codes 7..15
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Writeback and result
  ////////////////////////////////////////////////////////////////////////////

  // Write lands on the same edge as the result register
  assign we = inst_v & op_ok;
  assign wa = inst.r.rd;
  assign wd = result;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_v <= 1'b0;
    end else begin
      res_v <= we; // One pulse per executed instruction
    end
  end

  // Payload only, qualified by res_v
  always_ff @(posedge clk) begin
    res_rd   <= wa;
    res_data <= wd;
  end

endmodule

// ==== verilog/reg_file.sv ====
module reg_file
  import stream_core_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [REG_ADDR_WIDTH-1:0] rs1,
  input  logic [REG_ADDR_WIDTH-1:0] rs2,
  output logic [DATA_WIDTH-1:0]     rdata1,
  output logic [DATA_WIDTH-1:0]     rdata2,
  input  logic                      we,
  input  logic [REG_ADDR_WIDTH-1:0] wa,
  input  logic [DATA_WIDTH-1:0]     wd
);

  logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

  // All registers read as zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd; // Single write port
    end
  end

  // Async reads, a write shows up on the next cycle
  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

// ==== verilog/inst_mem.sv ====
module inst_mem
  import stream_core_pkg::*;
#(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_in_v,
  input  logic [INST_WIDTH-1:0] inst_in,
  input  logic                  run_en,
  output logic                  inst_out_v,
  output logic [INST_WIDTH-1:0] inst_out
);

  logic                  wr_en;    // Load beat accepted
  logic [ADDR_WIDTH-1:0] load_cnt; // Next free entry
  logic [ADDR_WIDTH-1:0] pc;       // Next entry to replay
  logic [ADDR_WIDTH-1:0] addr;     // Shared RAM address

  ////////////////////////////////////////////////////////////////////////////
  // Address and write control
  ////////////////////////////////////////////////////////////////////////////

  // Loads arriving during replay are lost
  assign wr_en = inst_in_v & ~run_en;
  assign addr  = run_en ? pc : load_cnt; // Read during replay, else write

  // Both counters wrap at the memory depth
  always_ff @(posedge clk) begin
    if (rst) begin
      load_cnt <= '0;
      pc       <= '0;
    end else begin
      if (wr_en) begin
        load_cnt <= load_cnt + 1'b1;
      end
      if (run_en) begin
        pc <= pc + 1'b1; // Program counter
      end
    end
  end

  // Data comes out of the read register one cycle after run_en
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_out_v <= 1'b0;
    end else begin
      inst_out_v <= run_en;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Instruction RAM
  ////////////////////////////////////////////////////////////////////////////

  sdp_bram #(
    .RAM_WIDTH  (INST_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_bram (
    .clk   (clk),
    .rst   (rst),
    .we    (wr_en),
    .waddr (addr),
    .raddr (addr),
    .din   (inst_in),
    .dout  (inst_out)
  );

endmodule

// ==== verilog/launch_delay.sv ====
module launch_delay #(
  parameter int DELAY = 16 // Replay delay in cycles, at least 2
) (
  input  logic clk,
  input  logic rst,
  input  logic v_in,
  output logic v_out
);

  logic [DELAY-1:0] shift_reg; // One stage per cycle of delay

  always_ff @(posedge clk) begin
    if (rst) begin
      shift_reg <= '0;
    end else begin
      shift_reg <= {shift_reg[DELAY-2:0], v_in}; // Oldest beat moves up
    end
  end

  // Last stage starts replay
  assign v_out = shift_reg[DELAY-1];

endmodule

// ==== verilog/sdp_bram.sv ====
module sdp_bram #(
  parameter int RAM_WIDTH  = 36,
  parameter int ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [ADDR_WIDTH-1:0] raddr,
  input  logic [RAM_WIDTH-1:0]  din,
  output logic [RAM_WIDTH-1:0]  dout
);

  // Block RAM array, contents survive reset
  logic [RAM_WIDTH-1:0] mem [2**ADDR_WIDTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= din;
    end
  end

  // Registered read, read-first on a collision
  // Output latch reset maps onto the BRAM output register reset
  always_ff @(posedge clk) begin
    if (rst) begin
      dout <= '0;
    end else begin
      dout <= mem[raddr];
    end
  end

endmodule

// ==== verilog/stream_core_pkg.sv ====
package stream_core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Field sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int INST_WIDTH     = 36; // Whole instruction word
  localparam int DATA_WIDTH     = 32; // Register and result size
  localparam int REG_ADDR_WIDTH = 3;  // Eight registers
  localparam int IMM_WIDTH      = 29; // Rest of the word after op and rd

  // Codes 7..15 are left undefined and act as nop
  typedef enum logic [3:0] {
    op_nop = 4'd0,
    op_ldi = 4'd1,
    op_add = 4'd2,
    op_sub = 4'd3,
    op_and = 4'd4,
    op_or  = 4'd5,
    op_xor = 4'd6
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word, op and rd sit in the same place in both views
  ////////////////////////////////////////////////////////////////////////////

  typedef union packed {
    struct packed {
      opcode_e                   op;     // [35:32]
      logic [REG_ADDR_WIDTH-1:0] rd;     // [31:29]
      logic [REG_ADDR_WIDTH-1:0] rs1;    // [28:26]
      logic [REG_ADDR_WIDTH-1:0] rs2;    // [25:23]
      logic [22:0]               unused; // Don't care
    } r;
    struct packed {
      opcode_e                   op;
      logic [REG_ADDR_WIDTH-1:0] rd;
      logic [IMM_WIDTH-1:0]      imm;    // Zero-extended on load
    } i;
  } inst_word_u;

endpackage
